//--- design/link_consts.svh
/* Frame layout and alignment constants shared by the aligner blocks.
   FRAME_LEN must be at least 5 so that the zero run is not empty. */

`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// Words per frame, FAW1 first and CRC2 last
`define FRAME_LEN 16

// Frame alignment words
`define FAW1_WORD 32'h000000BC
`define FAW2_WORD 32'h000000CB

// Fixed CRC patterns, no real CRC is computed
`define CRC1_WORD 32'h6A0A0000
`define CRC2_WORD 32'h6A0A6A0A

// Limits loaded at reset
`define DEF_MAX_REVIEWS 8'd4
`define DEF_MAX_RETRIES 8'd8

// Cycles the downstream datapath is held in reset
`define RESET_HOLD 16

// Rotator plus classifier depth
`define PIPE_FLUSH 3

`endif

//--- design/link_pkg.sv
/* Types shared by the word aligner.
   State encoding is one-hot and must stay that way for the FSM checks. */

package link_pkg;

   // Alignment FSM states
   typedef enum logic [5:0] {
      FLUSH  = 6'b000001,
      CHECK  = 6'b000010,
      REVIEW = 6'b000100,
      DONE   = 6'b001000,
      FAIL   = 6'b010000,
      HOLD   = 6'b100000
   } align_state_t;

   // Label of one received word
   typedef enum logic [2:0] {
      CLS_FAW1  = 3'd0,
      CLS_FAW2  = 3'd1,
      CLS_ZERO  = 3'd2,
      CLS_CRC1  = 3'd3,
      CLS_CRC2  = 3'd4,
      CLS_OTHER = 3'd5
   } word_class_t;

   // Configuration port opcodes
   typedef enum logic [1:0] {
      OP_SET_REVIEWS = 2'd0,
      OP_SET_RETRIES = 2'd1,
      OP_REALIGN     = 2'd2,
      OP_NOP         = 2'd3
   } cfg_op_t;

endpackage

//--- design/align_cfg_if.sv
/* Limits and realign request from the register block to the FSM,
   retry count back for status. No clock inside, both ends share clk_i. */

interface align_cfg_if;

   // Clean frames needed for lock
   logic [7:0] max_reviews;
   // Retries before a reset hold
   logic [7:0] max_retries;
   // One-cycle realign request
   logic       realign;
   // Current retry count from the FSM
   logic [7:0] retry_count;

   modport regs (
      output max_reviews,
      output max_retries,
      output realign,
      input  retry_count
   );

   modport fsm (
      input  max_reviews,
      input  max_retries,
      input  realign,
      output retry_count
   );

endinterface

//--- design/byte_rotator.sv
/* Byte-boundary shifter. Output is combinational from data_i at nonzero
   offsets. A slip takes effect on the cycle after slip_i. */

module byte_rotator (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic [31:0] data_i,
   input  logic        slip_i,
   output logic [31:0] data_o,
   output logic [1:0]  offset_o
);

   logic [31:0] prev_q;
   logic [1:0]  offset_q;
   logic [63:0] window;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         prev_q   <= '0;
         offset_q <= 2'd0;
      end else begin
         prev_q <= data_i;
         // Offset wraps from 3 back to 0
         if (slip_i) begin
            offset_q <= offset_q + 2'd1;
         end
      end
   end

   // Previous word leads, its MSB byte is byte 0
   assign window = {prev_q, data_i};

   always_comb begin
      case (offset_q)
         2'd0:    data_o = window[63:32];
         2'd1:    data_o = window[55:24];
         2'd2:    data_o = window[47:16];
         default: data_o = window[39:8];
      endcase
   end

   assign offset_o = offset_q;

   // FSM must leave time between slips
   a_no_back_to_back_slip: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slip_i |=> !slip_i);

endmodule

//--- design/word_classifier.sv
/* Two-stage word labeller, class valid two cycles after data_i.
   FAW2 ignores bit 31; anything not matching a pattern is CLS_OTHER. */

`include "link_consts.svh"

module word_classifier import link_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic [31:0] data_i,
   output word_class_t cls_o
);

   logic        faw1_hi_q, faw1_lo_q;
   logic        faw2_hi_q, faw2_lo_q;
   logic        crc1_hi_q, crc1_lo_q;
   logic        crc2_hi_q, crc2_lo_q;
   logic        zero_hi_q, zero_lo_q;
   logic        is_faw1, is_faw2, is_crc1, is_crc2, is_zero;
   word_class_t cls_d;
   word_class_t cls_q;

   // ------------------------------------------------------------------------
   // Stage 1 per-half compares
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         faw1_hi_q <= 1'b0;
         faw1_lo_q <= 1'b0;
         faw2_hi_q <= 1'b0;
         faw2_lo_q <= 1'b0;
         crc1_hi_q <= 1'b0;
         crc1_lo_q <= 1'b0;
         crc2_hi_q <= 1'b0;
         crc2_lo_q <= 1'b0;
         zero_hi_q <= 1'b0;
         zero_lo_q <= 1'b0;
      end else begin
         faw1_hi_q <= (data_i[31:16] == 16'(`FAW1_WORD >> 16));
         faw1_lo_q <= (data_i[15:0] == 16'(`FAW1_WORD));
         // Top bit of FAW2 is a don't care
         faw2_hi_q <= (data_i[30:16] == 15'(`FAW2_WORD >> 16));
         faw2_lo_q <= (data_i[15:0] == 16'(`FAW2_WORD));
         crc1_hi_q <= (data_i[31:16] == 16'(`CRC1_WORD >> 16));
         crc1_lo_q <= (data_i[15:0] == 16'(`CRC1_WORD));
         crc2_hi_q <= (data_i[31:16] == 16'(`CRC2_WORD >> 16));
         crc2_lo_q <= (data_i[15:0] == 16'(`CRC2_WORD));
         zero_hi_q <= (data_i[31:16] == 16'h0000);
         zero_lo_q <= (data_i[15:0] == 16'h0000);
      end
   end

   // ------------------------------------------------------------------------
   // Stage 2 whole-word class
   // ------------------------------------------------------------------------

   assign is_faw1 = faw1_hi_q & faw1_lo_q;
   assign is_faw2 = faw2_hi_q & faw2_lo_q;
   assign is_crc1 = crc1_hi_q & crc1_lo_q;
   assign is_crc2 = crc2_hi_q & crc2_lo_q;
   assign is_zero = zero_hi_q & zero_lo_q;

   always_comb begin
      if (is_faw1) begin
         cls_d = CLS_FAW1;
      end else if (is_faw2) begin
         cls_d = CLS_FAW2;
      end else if (is_crc1) begin
         cls_d = CLS_CRC1;
      end else if (is_crc2) begin
         cls_d = CLS_CRC2;
      end else if (is_zero) begin
         cls_d = CLS_ZERO;
      end else begin
         cls_d = CLS_OTHER;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cls_q <= CLS_OTHER;
      end else begin
         cls_q <= cls_d;
      end
   end

   assign cls_o = cls_q;

   // Patterns are disjoint so the priority order above never matters
   a_single_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({is_faw1, is_faw2, is_crc1, is_crc2, is_zero}));

endmodule

//--- design/align_fsm.sv
/* Hunt and review FSM. CHECK gives up after two frames without FAW1.
   Lock needs max_reviews clean frames counted from the FAW1 word. */

`include "link_consts.svh"

module align_fsm import link_pkg::*; (
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  word_class_t  cls_i,
   align_cfg_if.fsm     cfg,
   output logic         slip_o,
   output logic         align_done_o,
   output logic         rx_datapath_resetn_o
);

   align_state_t state_q;
   align_state_t state_d;
   logic [7:0]   timer_q;
   logic [7:0]   slot_q;
   logic [7:0]   clean_q;
   logic [7:0]   clean_next;
   logic [7:0]   retry_q;
   logic [7:0]   retry_next;
   word_class_t  expect_cls;
   logic         slot_ok;
   logic         frame_end;

   // Expected label for a slot, slot 0 being FAW1
   function automatic word_class_t slot_class(input logic [7:0] slot);
      word_class_t cls;
      if (slot == 8'd0) begin
         cls = CLS_FAW1;
      end else if (slot == 8'd1) begin
         cls = CLS_FAW2;
      end else if (slot == 8'(`FRAME_LEN - 2)) begin
         cls = CLS_CRC1;
      end else if (slot == 8'(`FRAME_LEN - 1)) begin
         cls = CLS_CRC2;
      end else begin
         cls = CLS_ZERO;
      end
      return cls;
   endfunction

   assign expect_cls = slot_class(slot_q);
   assign slot_ok    = (cls_i == expect_cls);
   assign frame_end  = (slot_q == 8'(`FRAME_LEN - 1));
   assign clean_next = clean_q + 8'd1;
   assign retry_next = retry_q + 8'd1;

   // ------------------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------------------

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         FLUSH: begin
            if (timer_q == 8'(`PIPE_FLUSH - 1)) begin
               state_d = CHECK;
            end
         end
         CHECK: begin
            // Two frames with no FAW1 means a wrong offset
            if (cls_i == CLS_FAW1) begin
               state_d = REVIEW;
            end else if (timer_q == 8'(2 * `FRAME_LEN - 1)) begin
               state_d = FAIL;
            end
         end
         REVIEW: begin
            if (cfg.realign || !slot_ok) begin
               state_d = FAIL;
            end else if (frame_end && clean_next >= cfg.max_reviews) begin
               state_d = DONE;
            end
         end
         DONE: begin
            if (cfg.realign) begin
               state_d = FAIL;
            end
         end
         FAIL: begin
            state_d = (retry_next >= cfg.max_retries) ? HOLD : FLUSH;
         end
         HOLD: begin
            if (timer_q == 8'(`RESET_HOLD - 1)) begin
               state_d = FLUSH;
            end
         end
         default: state_d = FLUSH;
      endcase
   end

   // ------------------------------------------------------------------------
   // State, counters and registered outputs
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q              <= FLUSH;
         timer_q              <= 8'd0;
         slot_q               <= 8'd0;
         clean_q              <= 8'd0;
         retry_q              <= 8'd0;
         align_done_o         <= 1'b0;
         rx_datapath_resetn_o <= 1'b1;
      end else begin
         state_q <= state_d;

         // Restarts on every state change, free running in REVIEW and DONE
         timer_q <= (state_d != state_q) ? 8'd0 : timer_q + 8'd1;

         // FAW1 seen in CHECK is slot 0, so REVIEW starts at slot 1
         if (state_q == CHECK) begin
            slot_q <= 8'd1;
         end else if (state_q == REVIEW) begin
            slot_q <= frame_end ? 8'd0 : slot_q + 8'd1;
         end

         if (state_q != REVIEW) begin
            clean_q <= 8'd0;
         end else if (frame_end && slot_ok) begin
            clean_q <= clean_next;
         end

         if (state_q == HOLD) begin
            retry_q <= 8'd0;
         end else if (state_q == FAIL) begin
            retry_q <= retry_next;
         end

         align_done_o         <= (state_q == DONE);
         rx_datapath_resetn_o <= (state_q != HOLD);
      end
   end

   assign slip_o          = (state_q == FAIL);
   assign cfg.retry_count = retry_q;

   a_state_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot(state_q));

   // A slip only ever follows a failed hunt, review or realign
   a_slip_after_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slip_o |-> $past(state_q) inside {CHECK, REVIEW, DONE});

endmodule

//--- design/align_cfg_regs.sv
/* Configuration registers written by a single-cycle strobe.
   Limits of 0 are stored as 1. Status lags the FSM count by one cycle. */

`include "link_consts.svh"

module align_cfg_regs import link_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        cfg_we_i,
   input  cfg_op_t     cfg_op_i,
   input  logic [7:0]  cfg_wdata_i,
   align_cfg_if.regs   cfg,
   output logic [7:0]  retry_count_o
);

   logic [7:0] max_reviews_q;
   logic [7:0] max_retries_q;
   logic       realign_q;
   logic [7:0] retry_count_q;
   logic [7:0] wdata_min1;

   // A zero limit would never let the FSM leave REVIEW or FAIL cleanly
   assign wdata_min1 = (cfg_wdata_i == 8'd0) ? 8'd1 : cfg_wdata_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         max_reviews_q <= `DEF_MAX_REVIEWS;
         max_retries_q <= `DEF_MAX_RETRIES;
         realign_q     <= 1'b0;
         retry_count_q <= 8'd0;
      end else begin
         realign_q     <= 1'b0;
         retry_count_q <= cfg.retry_count;
         if (cfg_we_i) begin
            case (cfg_op_i)
               OP_SET_REVIEWS: max_reviews_q <= wdata_min1;
               OP_SET_RETRIES: max_retries_q <= wdata_min1;
               OP_REALIGN:     realign_q     <= 1'b1;
               OP_NOP:         ;
               default:        ;
            endcase
         end
      end
   end

   assign cfg.max_reviews = max_reviews_q;
   assign cfg.max_retries = max_retries_q;
   assign cfg.realign     = realign_q;
   assign retry_count_o   = retry_count_q;

endmodule

//--- design/comma_align_top.sv
/* Receive word aligner. Status is on plain ports, no register read path.
   rx_datapath_resetn_o is meant for the logic behind this block. */

module comma_align_top import link_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic [31:0] rx_data_i,
   input  logic        cfg_we_i,
   input  logic [1:0]  cfg_op_i,
   input  logic [7:0]  cfg_wdata_i,
   output logic        align_done_o,
   output logic        rx_datapath_resetn_o,
   output logic [1:0]  byte_offset_o,
   output logic [7:0]  retry_count_o
);

   logic [31:0] rot_data;
   logic        slip;
   word_class_t cls;

   align_cfg_if i_cfg_if ();

   byte_rotator i_byte_rotator (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .data_i   (rx_data_i),
      .slip_i   (slip),
      .data_o   (rot_data),
      .offset_o (byte_offset_o)
   );

   word_classifier i_word_classifier (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (rot_data),
      .cls_o   (cls)
   );

   align_fsm i_align_fsm (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .cls_i                (cls),
      .cfg                  (i_cfg_if.fsm),
      .slip_o               (slip),
      .align_done_o         (align_done_o),
      .rx_datapath_resetn_o (rx_datapath_resetn_o)
   );

   align_cfg_regs i_align_cfg_regs (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_we_i      (cfg_we_i),
      .cfg_op_i      (cfg_op_t'(cfg_op_i)),
      .cfg_wdata_i   (cfg_wdata_i),
      .cfg           (i_cfg_if.regs),
      .retry_count_o (retry_count_o)
   );

endmodule

//--- test/tb_comma_align.sv
/* Table-driven testbench for the word aligner. Each row starts from reset,
   writes both limits, then streams frames delayed by a few random bytes. */

`include "link_consts.svh"

module tb_comma_align import link_pkg::*; ();

   typedef struct {
      int delay;
      int reviews;
      int retries;
      int corrupt;
      int realign;
      int exp_offset;
      int exp_done;
      int exp_retry;
   } case_t;

   localparam int NUM_CASES = 8;

   logic        clk_i;
   logic        rst_n_i;
   logic [31:0] rx_data_i;
   logic        cfg_we_i;
   logic [1:0]  cfg_op_i;
   logic [7:0]  cfg_wdata_i;
   logic        align_done_o;
   logic        rx_datapath_resetn_o;
   logic [1:0]  byte_offset_o;
   logic [7:0]  retry_count_o;

   case_t       cases [NUM_CASES];
   logic [7:0]  byte_q [$];
   int          stream_on;
   int          corrupt_on;
   int          done_seen;
   int          hold_seen;
   int          error_count;
   int          check_count;
   int          cycle_count = 0;
   int          cycle_limit;

   comma_align_top i_comma_align_top (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .rx_data_i            (rx_data_i),
      .cfg_we_i             (cfg_we_i),
      .cfg_op_i             (cfg_op_i),
      .cfg_wdata_i          (cfg_wdata_i),
      .align_done_o         (align_done_o),
      .rx_datapath_resetn_o (rx_datapath_resetn_o),
      .byte_offset_o        (byte_offset_o),
      .retry_count_o        (retry_count_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      end
   endtask

   // ------------------------------------------------------------------------
   // Frame generator
   // ------------------------------------------------------------------------

   task automatic push_frame();
      logic [31:0] word;
      for (int w = 0; w < `FRAME_LEN; w++) begin
         if (w == 0) begin
            word = `FAW1_WORD;
         end else if (w == 1) begin
            // Top bit of FAW2 is free, toggle it at random
            word = `FAW2_WORD | (32'($urandom) & 32'h8000_0000);
         end else if (w == `FRAME_LEN - 2) begin
            word = (corrupt_on != 0) ? (`CRC1_WORD ^ 32'h0000_0001) : `CRC1_WORD;
         end else if (w == `FRAME_LEN - 1) begin
            word = `CRC2_WORD;
         end else begin
            word = 32'h0;
         end
         for (int b = 3; b >= 0; b--) begin
            byte_q.push_back(word[8*b +: 8]);
         end
      end
   endtask

   // One clock on the falling edge, outputs sampled and next word driven
   task automatic step_cycle();
      logic [31:0] word;
      @(negedge clk_i);
      if (align_done_o) begin
         done_seen = 1;
      end
      if (!rx_datapath_resetn_o) begin
         hold_seen = 1;
      end
      if (stream_on != 0) begin
         if (byte_q.size() < 4) begin
            push_frame();
         end
         word = 32'h0;
         for (int b = 0; b < 4; b++) begin
            word = {word[23:0], byte_q.pop_front()};
         end
         rx_data_i = word;
      end
   endtask

   task automatic apply_reset();
      step_cycle();
      stream_on   = 0;
      rx_data_i   = 32'h0;
      byte_q.delete();
      cfg_we_i    = 1'b0;
      cfg_op_i    = OP_NOP;
      cfg_wdata_i = 8'h00;
      rst_n_i     = 1'b0;
      repeat (2) step_cycle();
      rst_n_i   = 1'b1;
      done_seen = 0;
      hold_seen = 0;
   endtask

   task automatic write_cfg(input cfg_op_t op, input int value);
      step_cycle();
      cfg_we_i    = 1'b1;
      cfg_op_i    = op;
      cfg_wdata_i = 8'(value);
      step_cycle();
      cfg_we_i    = 1'b0;
      cfg_op_i    = OP_NOP;
      cfg_wdata_i = 8'h00;
   endtask

   task automatic wait_done(input logic level, input int bound, output int waited);
      waited = 0;
      while (align_done_o !== level && waited < bound) begin
         step_cycle();
         waited++;
      end
   endtask

   function automatic int row_budget(input int idx);
      return (cases[idx].retries + 4) * (cases[idx].reviews + 2) * `FRAME_LEN;
   endfunction

   // Columns: delay, reviews, retries, corrupt CRC1, realign,
   // expected offset, expected done, expected retry count
   task automatic load_cases();
      cases[0] = '{0, 4, 8, 0, 0, 0, 1, 0};
      cases[1] = '{1, 4, 8, 0, 0, 1, 1, 1};
      cases[2] = '{2, 4, 8, 0, 0, 2, 1, 2};
      cases[3] = '{3, 4, 8, 0, 0, 3, 1, 3};
      cases[4] = '{0, 4, 4, 1, 0, 0, 0, 0};
      cases[5] = '{0, 4, 8, 0, 1, 0, 1, 4};
      cases[6] = '{0, 7, 8, 0, 0, 0, 1, 0};
      cases[7] = '{1, 1, 8, 0, 0, 1, 1, 1};
   endtask

   // ------------------------------------------------------------------------
   // One table row
   // ------------------------------------------------------------------------

   task automatic run_case(input int idx);
      case_t c;
      int    lock_wait;
      int    fall_wait;
      c = cases[idx];
      apply_reset();
      check_value("align_done_o", 32'(align_done_o), 32'd0);
      check_value("rx_datapath_resetn_o", 32'(rx_datapath_resetn_o), 32'd1);
      check_value("byte_offset_o", 32'(byte_offset_o), 32'd0);
      check_value("retry_count_o", 32'(retry_count_o), 32'd0);
      write_cfg(OP_SET_REVIEWS, c.reviews);
      write_cfg(OP_SET_RETRIES, c.retries);
      corrupt_on = c.corrupt;
      for (int b = 0; b < c.delay; b++) begin
         byte_q.push_back(8'($urandom));
      end
      stream_on = 1;
      if (c.corrupt != 0) begin
         // Never locks, watch for a fixed window
         repeat (row_budget(idx) / 2) step_cycle();
         check_value("align_done_o seen high", 32'(done_seen), 32'd0);
         check_value("rx_datapath_resetn_o seen low", 32'(hold_seen), 32'd1);
         check_value("retry_count_o below max_retries",
                     32'(retry_count_o < 8'(c.retries)), 32'd1);
      end else begin
         wait_done(1'b1, row_budget(idx), lock_wait);
         if (c.realign != 0) begin
            write_cfg(OP_REALIGN, 0);
            wait_done(1'b0, 8, fall_wait);
            check_value("align_done_o after realign", 32'(align_done_o), 32'd0);
            wait_done(1'b1, row_budget(idx), lock_wait);
         end
         check_value("align_done_o", 32'(align_done_o), 32'(c.exp_done));
         check_value("byte_offset_o", 32'(byte_offset_o), 32'(c.exp_offset));
         check_value("retry_count_o", 32'(retry_count_o), 32'(c.exp_retry));
         check_value("rx_datapath_resetn_o seen low", 32'(hold_seen), 32'd0);
         // Lock needs max_reviews whole clean frames
         check_value("lock wait at least max_reviews frames",
                     32'(lock_wait >= c.reviews * `FRAME_LEN), 32'd1);
         if (c.exp_retry == 0) begin
            // Aligned stream finds FAW1 within one frame
            check_value("lock wait within max_reviews + 2 frames",
                        32'(lock_wait <= (c.reviews + 2) * `FRAME_LEN), 32'd1);
         end
      end
   endtask

   initial begin
      rst_n_i     = 1'b0;
      rx_data_i   = 32'h0;
      cfg_we_i    = 1'b0;
      cfg_op_i    = OP_NOP;
      cfg_wdata_i = 8'h00;
      stream_on   = 0;
      corrupt_on  = 0;
      done_seen   = 0;
      hold_seen   = 0;
      error_count = 0;
      check_count = 0;
      void'($urandom(32'hc7a93a85));
      load_cases();
      cycle_limit = `RESET_HOLD;
      for (int i = 0; i < NUM_CASES; i++) begin
         cycle_limit += row_budget(i);
      end
      for (int i = 0; i < NUM_CASES; i++) begin
         run_case(i);
      end
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+design
design/link_pkg.sv
design/align_cfg_if.sv
design/byte_rotator.sv
design/word_classifier.sv
design/align_fsm.sv
design/align_cfg_regs.sv
design/comma_align_top.sv
test/tb_comma_align.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0 -Mdir obj_dir
TOP       = tb_comma_align
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir $(LOG)
